// ==== common/usb_phy_pkg.sv ====
// USB pin-control package with register map, field layouts, symbol codes and timing constants
package usb_phy_pkg;

  ////////////////////
  // Register map
  ////////////////////

  localparam int CSR_ADDR_W = 2;
  localparam int CSR_DATA_W = 32;

  localparam logic [CSR_ADDR_W-1:0] ADDR_DRIVE = 2'd0;
  localparam logic [CSR_ADDR_W-1:0] ADDR_CTRL  = 2'd1;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SEND  = 2'd2;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SENSE = 2'd3;

  ////////////////////
  // Timing constants
  ////////////////////

  // Longest symbol run one SEND command can carry
  localparam int SYM_MAX = 8;
  // Consecutive SE0 cycles that make a bus reset
  localparam int RESET_CYCLES = 16;
  localparam int RESET_CNT_W = $clog2(RESET_CYCLES + 1);
  // Depth of the receive pin synchronizer
  localparam int SYNC_STAGES = 2;

  ////////////////////
  // Line encodings
  ////////////////////

  // Transmit symbol, reserved code goes out as J
  typedef enum logic [1:0] {
    SYM_SE0  = 2'd0,
    SYM_J    = 2'd1,
    SYM_K    = 2'd2,
    SYM_RSVD = 2'd3
  } usb_sym_e;

  // Received line state
  typedef enum logic [1:0] {
    LINE_SE0 = 2'd0,
    LINE_J   = 2'd1,
    LINE_K   = 2'd2,
    LINE_SE1 = 2'd3
  } usb_line_e;

  ////////////////////
  // Field structs
  ////////////////////

  // Pin override word, en selects it over the core
  typedef struct packed {
    logic en;
    logic dp;
    logic dn;
    logic d;
    logic se0;
    logic oe;
    logic dp_pullup;
    logic dn_pullup;
    logic rx_enable;
  } usb_drive_t;

  // Core control, clr_reset is write-one and never stored
  typedef struct packed {
    logic connect;
    logic rx_enable;
    logic clr_reset;
  } usb_ctrl_t;

  // Symbol run command, syms[0] goes out first
  typedef struct packed {
    logic [3:0]                 count;
    usb_sym_e [SYM_MAX-1:0]     syms;
  } usb_send_t;

  // Transmit pin group
  typedef struct packed {
    logic d;
    logic se0;
    logic dp;
    logic dn;
    logic oe;
  } usb_tx_t;

  // Receive pin group
  typedef struct packed {
    logic dp;
    logic dn;
    logic d;
    logic pwr_sense;
  } usb_rx_t;

  // Read-only sense image
  typedef struct packed {
    usb_rx_t    rx;
    usb_tx_t    tx;
    usb_line_e  line;
    logic       busy;
    logic       reset_seen;
    logic [2:0] pad;
  } usb_sense_t;

  ////////////////////
  // Register word views
  ////////////////////

  typedef struct packed {
    logic [CSR_DATA_W-10:0] pad;
    usb_drive_t             f;
  } csr_drive_view_t;

  typedef struct packed {
    logic [CSR_DATA_W-4:0] pad;
    usb_ctrl_t             f;
  } csr_ctrl_view_t;

  typedef struct packed {
    logic [CSR_DATA_W-21:0] pad;
    usb_send_t              f;
  } csr_send_view_t;

  // One data word, decoded by the view the address selects
  typedef union packed {
    logic [CSR_DATA_W-1:0] raw;
    csr_drive_view_t       drive;
    csr_ctrl_view_t        ctrl;
    csr_send_view_t        send;
  } csr_word_u;

endpackage

// ==== verilog/usb_csr.sv ====
// Register block holding the override, control and symbol-run words plus the sense read-back
`timescale 1ns/1ps

module usb_csr (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Register port
  input  logic                                 csr_we_i,
  input  logic [usb_phy_pkg::CSR_ADDR_W-1:0]   csr_addr_i,
  input  logic [usb_phy_pkg::CSR_DATA_W-1:0]   csr_wdata_i,
  output logic [usb_phy_pkg::CSR_DATA_W-1:0]   csr_rdata_o,

  // Status from the datapath
  input  usb_phy_pkg::usb_sense_t              sense_i,
  input  logic                                 busy_i,
  input  usb_phy_pkg::usb_line_e               line_i,
  input  logic                                 reset_seen_i,

  // Stored fields and pulses
  output usb_phy_pkg::usb_drive_t              drive_o,
  output usb_phy_pkg::usb_ctrl_t               ctrl_o,
  output usb_phy_pkg::usb_send_t               send_o,
  output logic                                 send_start_o,
  output logic                                 clr_reset_o
);

  usb_phy_pkg::csr_word_u  wword;
  usb_phy_pkg::csr_word_u  rword;
  usb_phy_pkg::usb_drive_t drive_q;
  usb_phy_pkg::usb_ctrl_t  ctrl_q;
  usb_phy_pkg::usb_send_t  send_q;
  usb_phy_pkg::usb_sense_t sense_img;
  logic                    we_drive;
  logic                    we_ctrl;
  logic                    we_send;

  ////////////////////
  // Write decode
  ////////////////////

  // Same write word, seen through whichever view the address picks
  assign wword = csr_wdata_i;

  assign we_drive = csr_we_i && (csr_addr_i == usb_phy_pkg::ADDR_DRIVE);
  assign we_ctrl  = csr_we_i && (csr_addr_i == usb_phy_pkg::ADDR_CTRL);
  // SEND only lands while the sender is idle
  assign we_send  = csr_we_i && (csr_addr_i == usb_phy_pkg::ADDR_SEND) && !busy_i;

  // Start the sender in the strobe cycle, it latches on this edge
  assign send_start_o = we_send;
  // Write-one clear for the sticky bus reset flag
  assign clr_reset_o  = we_ctrl && wword.ctrl.f.clr_reset;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      drive_q <= '0;
      ctrl_q  <= '0;
      send_q  <= '0;
    end else begin
      if (we_drive) begin
        drive_q <= wword.drive.f;
      end
      if (we_ctrl) begin
        // Pulse bit is not kept
        ctrl_q.connect   <= wword.ctrl.f.connect;
        ctrl_q.rx_enable <= wword.ctrl.f.rx_enable;
        ctrl_q.clr_reset <= 1'b0;
      end
      if (we_send) begin
        send_q <= wword.send.f;
      end
    end
  end

  assign drive_o = drive_q;
  assign ctrl_o  = ctrl_q;
  // Sender latches on the strobe edge, so it takes the incoming command
  assign send_o  = we_send ? wword.send.f : send_q;

  ////////////////////
  // Read-back
  ////////////////////

  // Fill in the bits the IO mux cannot see
  always_comb begin
    sense_img            = sense_i;
    sense_img.line       = line_i;
    sense_img.busy       = busy_i;
    sense_img.reset_seen = reset_seen_i;
    sense_img.pad        = '0;
  end

  always_comb begin
    rword.raw = '0;
    case (csr_addr_i)
      usb_phy_pkg::ADDR_DRIVE: rword.drive.f = drive_q;
      usb_phy_pkg::ADDR_CTRL:  rword.ctrl.f  = ctrl_q;
      usb_phy_pkg::ADDR_SEND:  rword.send.f  = send_q;
      default:                 rword.raw     = usb_phy_pkg::CSR_DATA_W'(sense_img);
    endcase
  end

  assign csr_rdata_o = rword.raw;

endmodule

// ==== usb_iomux/usb_iomux.sv ====
// IO mux that synchronizes the receive pins and picks override or core values for the outputs
`timescale 1ns/1ps

module usb_iomux (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Asynchronous pins from the transceiver
  input  logic                    usb_rx_dp_i,
  input  logic                    usb_rx_dn_i,
  input  logic                    usb_rx_d_i,
  input  logic                    usb_sense_i,

  // Register side
  input  usb_phy_pkg::usb_drive_t drive_i,
  input  usb_phy_pkg::usb_ctrl_t  ctrl_i,

  // Core transmit group from the sender
  input  usb_phy_pkg::usb_tx_t    core_tx_i,

  // Pin outputs
  output usb_phy_pkg::usb_tx_t    usb_tx_o,
  output logic                    usb_dp_pullup_en_o,
  output logic                    usb_dn_pullup_en_o,
  output logic                    usb_rx_enable_o,

  // Synchronized receive group and sense bits
  output usb_phy_pkg::usb_rx_t    rx_sync_o,
  output usb_phy_pkg::usb_sense_t sense_o
);

  usb_phy_pkg::usb_rx_t rx_async;
  usb_phy_pkg::usb_rx_t sync_q [usb_phy_pkg::SYNC_STAGES];
  usb_phy_pkg::usb_tx_t tx_ovr;
  usb_phy_pkg::usb_tx_t tx_pin;

  ////////////////////
  // Input synchronizer
  ////////////////////

  assign rx_async.dp        = usb_rx_dp_i;
  assign rx_async.dn        = usb_rx_dn_i;
  assign rx_async.d         = usb_rx_d_i;
  assign rx_async.pwr_sense = usb_sense_i;

  // Plain flop chain, one stage per clock
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < usb_phy_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= rx_async;
      for (int i = 1; i < usb_phy_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign rx_sync_o = sync_q[usb_phy_pkg::SYNC_STAGES-1];

  ////////////////////
  // Output pin mux
  ////////////////////

  // Transmit group as the override word would drive it
  assign tx_ovr.d   = drive_i.d;
  assign tx_ovr.se0 = drive_i.se0;
  assign tx_ovr.dp  = drive_i.dp;
  assign tx_ovr.dn  = drive_i.dn;
  assign tx_ovr.oe  = drive_i.oe;

  // Ordinary logic muxes, no clock-mux cells available
  always_comb begin
    if (drive_i.en) begin
      tx_pin             = tx_ovr;
      usb_dp_pullup_en_o = drive_i.dp_pullup;
      usb_dn_pullup_en_o = drive_i.dn_pullup;
      usb_rx_enable_o    = drive_i.rx_enable;
    end else begin
      tx_pin             = core_tx_i;
      usb_dp_pullup_en_o = ctrl_i.connect;
      // Full speed only, D- never pulled up
      usb_dn_pullup_en_o = 1'b0;
      usb_rx_enable_o    = ctrl_i.rx_enable;
    end
  end

  assign usb_tx_o = tx_pin;

  ////////////////////
  // Sense bits
  ////////////////////

  // Line state, busy and reset flag are filled in by the register block
  always_comb begin
    sense_o    = '0;
    sense_o.rx = rx_sync_o;
    sense_o.tx = tx_pin;
  end

endmodule

// ==== verilog/usb_symbol_sender.sv ====
// Symbol sender that plays a programmed run of J, K and SE0 symbols onto the transmit group
`timescale 1ns/1ps

module usb_symbol_sender (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Command from the register block
  input  usb_phy_pkg::usb_send_t send_i,
  input  logic                   start_i,

  // Core transmit group
  output usb_phy_pkg::usb_tx_t   core_tx_o,
  output logic                   busy_o
);

  logic [2*usb_phy_pkg::SYM_MAX-1:0] sym_q;
  logic [3:0]                        rem_q;
  logic [3:0]                        run_len;
  usb_phy_pkg::usb_sym_e             cur_sym;

  ////////////////////
  // Run control
  ////////////////////

  // Counts above the shift depth are cut to a full run
  assign run_len = (send_i.count > 4'(usb_phy_pkg::SYM_MAX)) ?
                   4'(usb_phy_pkg::SYM_MAX) : send_i.count;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rem_q <= '0;
    end else if (start_i) begin
      rem_q <= run_len;
    end else if (rem_q != '0) begin
      rem_q <= rem_q - 4'd1;
    end
  end

  // Symbol payload shift register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sym_q <= '0;
    end else if (start_i) begin
      sym_q <= send_i.syms;
    end else if (rem_q != '0) begin
      // Next symbol moves into the low slot
      sym_q <= {2'b00, sym_q[2*usb_phy_pkg::SYM_MAX-1:2]};
    end
  end

  assign busy_o = (rem_q != '0);

  ////////////////////
  // Symbol decode
  ////////////////////

  assign cur_sym = usb_phy_pkg::usb_sym_e'(sym_q[1:0]);

  always_comb begin
    // Idle line is J with the driver off
    core_tx_o.dp  = 1'b1;
    core_tx_o.dn  = 1'b0;
    core_tx_o.d   = 1'b1;
    core_tx_o.se0 = 1'b0;
    core_tx_o.oe  = busy_o;
    if (busy_o) begin
      case (cur_sym)
        usb_phy_pkg::SYM_SE0: begin
          core_tx_o.dp  = 1'b0;
          core_tx_o.d   = 1'b0;
          core_tx_o.se0 = 1'b1;
        end
        usb_phy_pkg::SYM_K: begin
          core_tx_o.dp = 1'b0;
          core_tx_o.dn = 1'b1;
          core_tx_o.d  = 1'b0;
        end
        // J and the reserved code keep the idle J levels
        default: ;
      endcase
    end
  end

endmodule

// ==== verilog/usb_line_monitor.sv ====
// Line monitor that decodes the received D+/D- pair and flags a bus reset on a long SE0
`timescale 1ns/1ps

module usb_line_monitor (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Synchronized receive group
  input  usb_phy_pkg::usb_rx_t   rx_sync_i,
  // Write-one clear from the register block
  input  logic                   clr_reset_i,

  output usb_phy_pkg::usb_line_e line_o,
  output logic                   bus_reset_o,
  output logic                   reset_seen_o
);

  logic [usb_phy_pkg::RESET_CNT_W-1:0] se0_cnt_q;
  logic                                reset_seen_q;
  logic                                is_se0;

  ////////////////////
  // Line decode
  ////////////////////

  always_comb begin
    case ({rx_sync_i.dp, rx_sync_i.dn})
      2'b00:   line_o = usb_phy_pkg::LINE_SE0;
      2'b10:   line_o = usb_phy_pkg::LINE_J;
      2'b01:   line_o = usb_phy_pkg::LINE_K;
      default: line_o = usb_phy_pkg::LINE_SE1;
    endcase
  end

  assign is_se0 = (line_o == usb_phy_pkg::LINE_SE0);

  ////////////////////
  // SE0 run counter
  ////////////////////

  // Holds the SE0 cycles seen before the current one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      se0_cnt_q <= '0;
    end else if (!is_se0) begin
      se0_cnt_q <= '0;
    end else if (se0_cnt_q != usb_phy_pkg::RESET_CNT_W'(usb_phy_pkg::RESET_CYCLES)) begin
      // Saturate so a long reset pulses only once
      se0_cnt_q <= se0_cnt_q + 1'b1;
    end
  end

  // Current cycle makes the run exactly RESET_CYCLES long
  assign bus_reset_o = is_se0 &&
      (se0_cnt_q == usb_phy_pkg::RESET_CNT_W'(usb_phy_pkg::RESET_CYCLES - 1));

  ////////////////////
  // Sticky flag
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reset_seen_q <= 1'b0;
    end else if (bus_reset_o) begin
      // A new reset wins over a clear in the same cycle
      reset_seen_q <= 1'b1;
    end else if (clr_reset_i) begin
      reset_seen_q <= 1'b0;
    end
  end

  // Visible already in the pulse cycle
  assign reset_seen_o = reset_seen_q | bus_reset_o;

endmodule

// ==== verilog/usb_phy_top.sv ====
// Top level of the USB pin-control subsystem joining registers, sender, monitor and IO mux
`timescale 1ns/1ps

module usb_phy_top (
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Register port
  input  logic                                 csr_we_i,
  input  logic [usb_phy_pkg::CSR_ADDR_W-1:0]   csr_addr_i,
  input  logic [usb_phy_pkg::CSR_DATA_W-1:0]   csr_wdata_i,
  output logic [usb_phy_pkg::CSR_DATA_W-1:0]   csr_rdata_o,

  // USB pins
  input  logic                                 usb_rx_dp_i,
  input  logic                                 usb_rx_dn_i,
  input  logic                                 usb_rx_d_i,
  input  logic                                 usb_sense_i,
  output usb_phy_pkg::usb_tx_t                 usb_tx_o,
  output logic                                 usb_dp_pullup_en_o,
  output logic                                 usb_dn_pullup_en_o,
  output logic                                 usb_rx_enable_o,
  output logic                                 usb_bus_reset_o
);

  usb_phy_pkg::usb_drive_t drive;
  usb_phy_pkg::usb_ctrl_t  ctrl;
  usb_phy_pkg::usb_send_t  send;
  usb_phy_pkg::usb_tx_t    core_tx;
  usb_phy_pkg::usb_rx_t    rx_sync;
  usb_phy_pkg::usb_sense_t sense;
  usb_phy_pkg::usb_line_e  line;
  logic                    send_start;
  logic                    clr_reset;
  logic                    busy;
  logic                    reset_seen;

  ////////////////////
  // Input side
  ////////////////////

  usb_csr u_csr (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .sense_i      (sense),
    .busy_i       (busy),
    .line_i       (line),
    .reset_seen_i (reset_seen),
    .drive_o      (drive),
    .ctrl_o       (ctrl),
    .send_o       (send),
    .send_start_o (send_start),
    .clr_reset_o  (clr_reset)
  );

  ////////////////////
  // Processing
  ////////////////////

  usb_symbol_sender u_sender (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .send_i    (send),
    .start_i   (send_start),
    .core_tx_o (core_tx),
    .busy_o    (busy)
  );

  usb_line_monitor u_monitor (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_sync_i    (rx_sync),
    .clr_reset_i  (clr_reset),
    .line_o       (line),
    .bus_reset_o  (usb_bus_reset_o),
    .reset_seen_o (reset_seen)
  );

  ////////////////////
  // Pin side
  ////////////////////

  usb_iomux u_iomux (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .usb_rx_dp_i        (usb_rx_dp_i),
    .usb_rx_dn_i        (usb_rx_dn_i),
    .usb_rx_d_i         (usb_rx_d_i),
    .usb_sense_i        (usb_sense_i),
    .drive_i            (drive),
    .ctrl_i             (ctrl),
    .core_tx_i          (core_tx),
    .usb_tx_o           (usb_tx_o),
    .usb_dp_pullup_en_o (usb_dp_pullup_en_o),
    .usb_dn_pullup_en_o (usb_dn_pullup_en_o),
    .usb_rx_enable_o    (usb_rx_enable_o),
    .rx_sync_o          (rx_sync),
    .sense_o            (sense)
  );

endmodule

// ==== testbench/usb_phy_tb.sv ====
// Self-checking testbench for the USB pin-control subsystem with register, pin and line checks
`timescale 1ns/1ps

module usb_phy_tb;

  localparam int RUNS      = 6;
  localparam int RX_ROUNDS = 8;
  // Rough cycle cost of every test, summed
  localparam int TEST_CYCLES = 10 + 4 + 4 * 8 + 4 * 6 + RUNS * (usb_phy_pkg::SYM_MAX + 6) +
                               RX_ROUNDS * 4 + 3 * usb_phy_pkg::RESET_CYCLES + 30;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                                clk_i;
  logic                                rst_i;
  logic                                csr_we_i;
  logic [usb_phy_pkg::CSR_ADDR_W-1:0]  csr_addr_i;
  logic [usb_phy_pkg::CSR_DATA_W-1:0]  csr_wdata_i;
  logic [usb_phy_pkg::CSR_DATA_W-1:0]  csr_rdata_o;
  logic                                usb_rx_dp_i;
  logic                                usb_rx_dn_i;
  logic                                usb_rx_d_i;
  logic                                usb_sense_i;
  usb_phy_pkg::usb_tx_t                usb_tx_o;
  logic                                usb_dp_pullup_en_o;
  logic                                usb_dn_pullup_en_o;
  logic                                usb_rx_enable_o;
  logic                                usb_bus_reset_o;

  int          errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;
  int          cycles;
  logic [31:0] rdata;

  usb_phy_top dut_i (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .csr_we_i           (csr_we_i),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata_i),
    .csr_rdata_o        (csr_rdata_o),
    .usb_rx_dp_i        (usb_rx_dp_i),
    .usb_rx_dn_i        (usb_rx_dn_i),
    .usb_rx_d_i         (usb_rx_d_i),
    .usb_sense_i        (usb_sense_i),
    .usb_tx_o           (usb_tx_o),
    .usb_dp_pullup_en_o (usb_dp_pullup_en_o),
    .usb_dn_pullup_en_o (usb_dn_pullup_en_o),
    .usb_rx_enable_o    (usb_rx_enable_o),
    .usb_bus_reset_o    (usb_bus_reset_o)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Bus reset is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (rst_i) usb_bus_reset_o |=> !usb_bus_reset_o)
    else begin
      errors++;
      $display("Fail %0t: bus reset pulse lasted more than one cycle", $time);
    end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Strobe lasts one cycle, returns on the edge that samples it
  task automatic write_csr(input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    csr_we_i    <= 1'b1;
    csr_addr_i  <= addr;
    csr_wdata_i <= data;
    @(posedge clk_i);
    csr_we_i    <= 1'b0;
  endtask

  task automatic read_csr(input logic [1:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    csr_addr_i <= addr;
    @(negedge clk_i);
    data = csr_rdata_o;
  endtask

  // Pin group d, se0, dp, dn, oe for one symbol with the driver on
  function automatic logic [4:0] sym_to_tx(input logic [1:0] sym);
    case (sym)
      2'd0:    sym_to_tx = 5'b01001;
      2'd2:    sym_to_tx = 5'b00011;
      // J, reserved code goes out the same way
      default: sym_to_tx = 5'b10101;
    endcase
  endfunction

  function automatic usb_phy_pkg::usb_line_e line_of(input logic dp, input logic dn);
    if (!dp && !dn) begin
      line_of = usb_phy_pkg::LINE_SE0;
    end else if (dp && !dn) begin
      line_of = usb_phy_pkg::LINE_J;
    end else if (!dp && dn) begin
      line_of = usb_phy_pkg::LINE_K;
    end else begin
      line_of = usb_phy_pkg::LINE_SE1;
    end
  endfunction

  // SE0 on the pins for len cycles, then J, counting monitor pulses
  task automatic hold_se0(input int len, output int pulses, output int first_at);
    pulses   = 0;
    first_at = -1;
    @(posedge clk_i);
    usb_rx_dp_i <= 1'b0;
    usb_rx_dn_i <= 1'b0;
    for (int i = 0; i < len + usb_phy_pkg::SYNC_STAGES + 2; i++) begin
      @(negedge clk_i);
      if (usb_bus_reset_o) begin
        pulses++;
        if (first_at < 0) begin
          first_at = i;
        end
      end
      @(posedge clk_i);
      if (i == len - 1) begin
        usb_rx_dp_i <= 1'b1;
      end
    end
  endtask

  task automatic report_test(input string name, input int start);
    if (errors == start) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail with %0d errors", name, errors - start);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic after_reset();
    int                      start;
    usb_phy_pkg::usb_sense_t sv;
    start = errors;
    @(negedge clk_i);
    expect_eq({usb_tx_o.oe, usb_dp_pullup_en_o, usb_dn_pullup_en_o, usb_rx_enable_o},
              4'b0000, "oe, pull-ups and rx_enable after reset");
    expect_eq(usb_bus_reset_o, 1'b0, "bus reset after reset");
    read_csr(usb_phy_pkg::ADDR_SENSE, rdata);
    sv = rdata[15:0];
    expect_eq({sv.busy, sv.reset_seen}, 2'b00, "busy and reset_seen after reset");
    report_test("after reset", start);
  endtask

  task automatic override_pins();
    int                      start;
    logic [31:0]             bits;
    usb_phy_pkg::usb_drive_t dv;
    start = errors;
    for (int r = 0; r < 4; r++) begin
      bits = $urandom;
      dv   = {1'b1, bits[7:0]};
      write_csr(usb_phy_pkg::ADDR_DRIVE, {23'd0, dv});
      // Pins hold the override from the next cycle on
      repeat (3) begin
        @(negedge clk_i);
        expect_eq({usb_tx_o, usb_dp_pullup_en_o, usb_dn_pullup_en_o, usb_rx_enable_o},
                  {dv.d, dv.se0, dv.dp, dv.dn, dv.oe, dv.dp_pullup, dv.dn_pullup, dv.rx_enable},
                  $sformatf("override round %0d pins", r));
      end
      read_csr(usb_phy_pkg::ADDR_DRIVE, rdata);
      expect_eq(rdata, {23'd0, dv}, "DRIVE read-back");
    end
    // Hand the pins back to the core
    write_csr(usb_phy_pkg::ADDR_DRIVE, 32'd0);
    report_test("override", start);
  endtask

  task automatic core_control();
    int   start;
    logic connect;
    logic rx_en;
    start = errors;
    for (int c = 0; c < 4; c++) begin
      connect = c[1];
      rx_en   = c[0];
      write_csr(usb_phy_pkg::ADDR_CTRL, {29'd0, connect, rx_en, 1'b0});
      @(negedge clk_i);
      // D- pull-up stays low at full speed
      expect_eq({usb_dp_pullup_en_o, usb_dn_pullup_en_o, usb_rx_enable_o, usb_tx_o.oe},
                {connect, 1'b0, rx_en, 1'b0}, $sformatf("core pins, control %0d", c));
      read_csr(usb_phy_pkg::ADDR_CTRL, rdata);
      expect_eq(rdata, {29'd0, connect, rx_en, 1'b0}, "CTRL read-back");
    end
    report_test("core path", start);
  endtask

  task automatic symbol_runs();
    int                      start;
    int                      cnt;
    logic [15:0]             syms;
    logic [31:0]             word;
    usb_phy_pkg::usb_sense_t sv;
    start = errors;
    for (int r = 0; r < RUNS; r++) begin
      cnt  = ($urandom % usb_phy_pkg::SYM_MAX) + 1;
      syms = 16'($urandom);
      word = {12'd0, 4'(cnt), syms};
      @(posedge clk_i);
      csr_we_i    <= 1'b1;
      csr_addr_i  <= usb_phy_pkg::ADDR_SEND;
      csr_wdata_i <= word;
      @(negedge clk_i);
      expect_eq(usb_tx_o.oe, 1'b0, "oe in the strobe cycle");
      @(posedge clk_i);
      // Second SEND arrives in the first run cycle
      csr_wdata_i <= {12'd0, 4'd8, ~syms};
      for (int k = 0; k < cnt; k++) begin
        @(negedge clk_i);
        expect_eq(usb_tx_o, sym_to_tx(syms[2*k +: 2]), $sformatf("run %0d symbol %0d", r, k));
        if (k > 0) begin
          sv = csr_rdata_o[15:0];
          expect_eq(sv.busy, 1'b1, $sformatf("run %0d busy at symbol %0d", r, k));
        end
        @(posedge clk_i);
        if (k == 0) begin
          csr_we_i   <= 1'b0;
          csr_addr_i <= usb_phy_pkg::ADDR_SENSE;
        end
      end
      @(negedge clk_i);
      sv = csr_rdata_o[15:0];
      expect_eq({usb_tx_o.oe, sv.busy}, 2'b00, $sformatf("run %0d oe and busy after end", r));
      read_csr(usb_phy_pkg::ADDR_SEND, rdata);
      expect_eq(rdata, word, "SEND keeps the first command");
    end
    report_test("symbol run", start);
  endtask

  task automatic receive_sync();
    int                      start;
    logic [3:0]              pins;
    logic [3:0]              prev;
    usb_phy_pkg::usb_sense_t sv;
    start = errors;
    prev  = {usb_rx_dp_i, usb_rx_dn_i, usb_rx_d_i, usb_sense_i};
    for (int r = 0; r < RX_ROUNDS; r++) begin
      pins = 4'($urandom);
      @(posedge clk_i);
      {usb_rx_dp_i, usb_rx_dn_i, usb_rx_d_i, usb_sense_i} <= pins;
      csr_addr_i <= usb_phy_pkg::ADDR_SENSE;
      repeat (usb_phy_pkg::SYNC_STAGES - 1) @(posedge clk_i);
      @(negedge clk_i);
      sv = csr_rdata_o[15:0];
      expect_eq(sv.rx, prev, $sformatf("round %0d rx one cycle early", r));
      @(posedge clk_i);
      @(negedge clk_i);
      sv = csr_rdata_o[15:0];
      expect_eq(sv.rx, pins, $sformatf("round %0d synchronized rx", r));
      expect_eq(sv.line, line_of(pins[3], pins[2]), $sformatf("round %0d line state", r));
      // Idle J with the driver off
      expect_eq(sv.tx, 5'b10100, "pin-side tx in sense");
      prev = pins;
    end
    report_test("receive sync", start);
  endtask

  task automatic bus_reset_detect();
    int                      start;
    int                      pulses;
    int                      at;
    usb_phy_pkg::usb_sense_t sv;
    start = errors;
    @(posedge clk_i);
    usb_rx_dp_i <= 1'b1;
    usb_rx_dn_i <= 1'b0;
    repeat (usb_phy_pkg::SYNC_STAGES + 1) @(posedge clk_i);
    // Clear any flag left over from random line states
    write_csr(usb_phy_pkg::ADDR_CTRL, 32'h7);
    hold_se0(usb_phy_pkg::RESET_CYCLES - 4, pulses, at);
    expect_eq(pulses, 0, "bus reset pulses for a short SE0");
    read_csr(usb_phy_pkg::ADDR_SENSE, rdata);
    sv = rdata[15:0];
    expect_eq(sv.reset_seen, 1'b0, "reset_seen after a short SE0");
    hold_se0(usb_phy_pkg::RESET_CYCLES + 8, pulses, at);
    expect_eq(pulses, 1, "bus reset pulses for a long SE0");
    expect_eq(at, usb_phy_pkg::SYNC_STAGES + usb_phy_pkg::RESET_CYCLES - 1,
              "bus reset pulse cycle");
    read_csr(usb_phy_pkg::ADDR_SENSE, rdata);
    sv = rdata[15:0];
    expect_eq(sv.reset_seen, 1'b1, "reset_seen after a long SE0");
    write_csr(usb_phy_pkg::ADDR_CTRL, 32'h7);
    read_csr(usb_phy_pkg::ADDR_SENSE, rdata);
    sv = rdata[15:0];
    expect_eq(sv.reset_seen, 1'b0, "reset_seen after clr_reset");
    report_test("bus reset", start);
  endtask

  ////////////////////
  // Run control
  ////////////////////

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(95987));
    errors       = 0;
    checks       = 0;
    tests_passed = 0;
    tests_failed = 0;
    // Line idles at J with VBUS present
    csr_we_i     = 1'b0;
    csr_addr_i   = '0;
    csr_wdata_i  = '0;
    usb_rx_dp_i  = 1'b1;
    usb_rx_dn_i  = 1'b0;
    usb_rx_d_i   = 1'b1;
    usb_sense_i  = 1'b1;
    rst_i        = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    after_reset();
    override_pins();
    core_control();
    symbol_runs();
    receive_sync();
    bus_reset_detect();
    $display("Tests passed %0d, tests failed %0d, checks %0d, failed checks %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
common/usb_phy_pkg.sv
verilog/usb_csr.sv
usb_iomux/usb_iomux.sv
verilog/usb_symbol_sender.sv
verilog/usb_line_monitor.sv
verilog/usb_phy_top.sv
testbench/usb_phy_tb.sv
